// ==== list.f ====
logic/mem_pkg.sv
logic/mem_req_port.sv
logic/tagged_mem.sv
logic/load_return_queue.sv
logic/mem_subsys.sv
tests/mem_subsys_tb.sv

// ==== Makefile ====
# Verilator flow for the tagged memory subsystem

TOP = mem_subsys_tb

.PHONY: lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	rm -f sim.log
	verilator --binary --timing -j 0 --top-module $(TOP) --Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Test OK" sim.log && echo "simulation passed" || \
		(echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== tests/mem_subsys_tb.sv ====
module mem_subsys_tb import mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_OPS       = 400;
	localparam int RESET_CYCLES  = 10;
	localparam int ACK_DELAY_W   = 3;
	localparam int MAX_ACK_DELAY = (1 << ACK_DELAY_W) - 1;
	// per op budget, worst latency plus tag wait plus a slow host and slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES
		+ NUM_OPS * (MEM_LATENCY + NUM_MEM_TAGS + MAX_ACK_DELAY + 8);
	localparam int QUIET_CYCLES  = 2 * (MEM_LATENCY + NUM_MEM_TAGS);
	localparam logic [31:0] LFSR_SEED = 32'h876eee3e;

	logic         clock = 1'b0;
	logic         arst_n;
	logic         in_req;
	bus_command_t in_cmd;
	mem_addr_t    in_addr;
	mem_data_t    in_data;
	logic         in_ack;
	logic         out_req;
	mem_tag_t     out_tag;
	mem_data_t    out_data;
	logic         out_ack;

	// reference model
	mem_data_t mirror [MEM_LINES];
	mem_data_t expected_q [$];
	int        loads_acked;
	int        returns_seen;
	int        cycle_count;

	// two random streams, one per process, same seed
	logic [31:0] op_lfsr;
	logic [31:0] ack_lfsr;

	// previous-cycle view for the protocol monitor
	logic      prev_in_ack;
	logic      prev_out_req;
	mem_tag_t  prev_out_tag;
	mem_data_t prev_out_data;

	mem_subsys DUT (
		.clock, .arst_n,
		.in_req, .in_cmd, .in_addr, .in_data, .in_ack,
		.out_req, .out_tag, .out_data, .out_ack
	);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// random numbers
	////////////////////////////////////////////////////////////////////////////

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	// one step per bit, msb first
	function automatic logic [63:0] take_random_bits(inout logic [31:0] state,
		input int nbits);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < nbits; i++) begin
			state = step_lfsr(state);
			bits  = {bits[62:0], state[0]};
		end
		return bits;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_data(input string name, input mem_data_t expected,
		input mem_data_t actual);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_tag(input string name, input mem_tag_t expected,
		input mem_tag_t actual);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%0d actual=%0d",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%b actual=%b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// host request side
	////////////////////////////////////////////////////////////////////////////

	// one full four-phase request, model updated at ack
	task automatic run_request(input bus_command_t cmd, input mem_addr_t addr,
		input mem_data_t data);
		in_cmd  <= cmd;
		in_addr <= addr;
		in_data <= data;
		in_req  <= 1'b1;
		do @(negedge clock); while (!in_ack);
		if (cmd == BUS_LOAD) begin
			expected_q.push_back(mirror[addr]);
			loads_acked++;
		end else begin
			mirror[addr] = data;
		end
		in_req <= 1'b0;
		do @(negedge clock); while (in_ack);
	endtask

	initial begin
		logic      is_load;
		mem_addr_t addr;
		mem_data_t data;
		in_req       = 1'b0;
		in_cmd       = BUS_NONE;
		in_addr      = '0;
		in_data      = '0;
		out_ack      = 1'b0;
		arst_n       = 1'b0;
		op_lfsr      = LFSR_SEED;
		ack_lfsr     = LFSR_SEED;
		loads_acked  = 0;
		returns_seen = 0;
		for (int i = 0; i < MEM_LINES; i++)
			mirror[i] = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		// quiet outputs before the first request
		check_flag("in_ack", 1'b0, in_ack);
		check_flag("out_req", 1'b0, out_req);
		check_tag("out_tag", '0, out_tag);
		for (int op = 0; op < NUM_OPS; op++) begin
			is_load = take_random_bits(op_lfsr, 1) != '0;
			addr    = mem_addr_t'(take_random_bits(op_lfsr, LINE_ADDR_W));
			if (is_load) begin
				run_request(BUS_LOAD, addr, '0);
			end else begin
				data = take_random_bits(op_lfsr, 64);
				run_request(BUS_STORE, addr, data);
			end
		end
		// drain, then a quiet stretch to catch extra returns
		while (returns_seen < loads_acked)
			@(negedge clock);
		repeat (QUIET_CYCLES) @(negedge clock);
		if ((returns_seen != loads_acked) || (expected_q.size() != 0)) begin
			$display("returned %0d loads but %0d were acknowledged",
				returns_seen, loads_acked);
			abort_run();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// host return side
	////////////////////////////////////////////////////////////////////////////

	initial begin
		mem_data_t held_data;
		int        delay;
		@(posedge arst_n);
		forever begin
			@(negedge clock);
			if (out_req) begin
				if ((out_tag == '0) || (int'(out_tag) > NUM_MEM_TAGS)) begin
					$display("return tag %0d is outside 1 to %0d at time %0t",
						out_tag, NUM_MEM_TAGS, $time);
					abort_run();
				end
				if (expected_q.size() == 0) begin
					$display("a load returned at time %0t with no load outstanding", $time);
					abort_run();
				end
				held_data = expected_q.pop_front();
				check_data("out_data", held_data, out_data);
				// slow host, random ack delay
				delay = int'(take_random_bits(ack_lfsr, ACK_DELAY_W));
				for (int d = 0; d < delay; d++) begin
					@(negedge clock);
					check_flag("out_req", 1'b1, out_req);
				end
				out_ack <= 1'b1;
				do @(negedge clock); while (out_req);
				out_ack <= 1'b0;
				returns_seen++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol monitor and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (arst_n) begin
			// ack only answers a live request
			if (in_ack && !prev_in_ack)
				check_flag("in_req", 1'b1, in_req);
			// payload frozen while out_req is high
			if (prev_out_req && out_req) begin
				check_tag("out_tag", prev_out_tag, out_tag);
				check_data("out_data", prev_out_data, out_data);
			end
			// out_req drops only after out_ack
			if (prev_out_req && !out_req)
				check_flag("out_ack", 1'b1, out_ack);
			// new item only after the old ack is gone
			if (!prev_out_req && out_req)
				check_flag("out_ack", 1'b0, out_ack);
		end
		prev_in_ack   = in_ack;
		prev_out_req  = out_req;
		prev_out_tag  = out_tag;
		prev_out_data = out_data;
	end

	initial cycle_count = 0;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			abort_run();
		end
	end

endmodule

// ==== logic/mem_subsys.sv ====
module mem_subsys import mem_pkg::*; (
	input  logic         clock,
	input  logic         arst_n,

	// host request port
	input  logic         in_req,
	input  bus_command_t in_cmd,
	input  mem_addr_t    in_addr,
	input  mem_data_t    in_data,
	output logic         in_ack,

	// host return port
	output logic         out_req,
	output mem_tag_t     out_tag,
	output mem_data_t    out_data,
	input  logic         out_ack
);

	////////////////////////////////////////////////////////////////////////////
	// internal buses
	////////////////////////////////////////////////////////////////////////////

	// front-end to memory
	bus_command_t mem_cmd;
	mem_addr_t    mem_addr;
	mem_data_t    mem_data;
	mem_tag_t     mem_response;

	// memory to collector
	mem_tag_t     mem_tag;
	mem_data_t    mem_data_out;

	// credit loop
	logic         load_room;
	logic         load_issue;

	mem_req_port u_req_port (
		.clock, .arst_n,
		.in_req, .in_cmd, .in_addr, .in_data, .in_ack,
		.mem_cmd, .mem_addr, .mem_data, .mem_response,
		.load_room, .load_issue
	);

	tagged_mem u_mem (
		.clock, .arst_n,
		.mem_cmd, .mem_addr, .mem_data,
		.mem_response, .mem_tag, .mem_data_out
	);

	load_return_queue u_ret_queue (
		.clock, .arst_n,
		.mem_tag, .mem_data_out,
		.load_issue, .load_room,
		.out_req, .out_tag, .out_data, .out_ack
	);

endmodule

// ==== logic/load_return_queue.sv ====
module load_return_queue import mem_pkg::*; (
	input  logic      clock,
	input  logic      arst_n,

	// memory return bus
	input  mem_tag_t  mem_tag,
	input  mem_data_t mem_data_out,

	// credit
	input  logic      load_issue,
	output logic      load_room,

	// host return side, four-phase
	output logic      out_req,
	output mem_tag_t  out_tag,
	output mem_data_t out_data,
	input  logic      out_ack
);

	// queue body holds payload only
	mem_tag_t  q_tag  [QUEUE_DEPTH];
	mem_data_t q_data [QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;
	logic [QUEUE_CNT_W-1:0] reserved;
	logic [QUEUE_CNT_W:0]   committed;
	logic                   push;
	logic                   pop;
	logic                   launch;

	assign push = (mem_tag != '0);

	// entry leaves when the handshake completes
	assign pop = out_req && out_ack;

	// next item only once the previous ack has dropped
	assign launch = !out_req && !out_ack && (count != '0);

	////////////////////////////////////////////////////////////////////////////
	// credit
	////////////////////////////////////////////////////////////////////////////

	// queued entries plus loads still in the memory
	assign committed = {1'b0, count} + {1'b0, reserved};
	assign load_room = committed < (QUEUE_CNT_W + 1)'(QUEUE_DEPTH);

	////////////////////////////////////////////////////////////////////////////
	// queue
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			q_tag[wr_ptr]  <= mem_tag;
			q_data[wr_ptr] <= mem_data_out;
		end
		// payload latched at launch and steady through the handshake
		if (launch)
			out_data <= q_data[rd_ptr];
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			reserved <= '0;
			out_req  <= 1'b0;
			out_tag  <= '0;
		end else begin
			// explicit wrap since the depth is not a power of two
			if (push)
				wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0
					: wr_ptr + QUEUE_PTR_W'(1);
			if (pop)
				rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0
					: rd_ptr + QUEUE_PTR_W'(1);

			case ({push, pop})
				2'b10: count <= count + QUEUE_CNT_W'(1);
				2'b01: count <= count - QUEUE_CNT_W'(1);
				default: count <= count;
			endcase

			// a reservation turns into an entry when it returns
			case ({load_issue, push})
				2'b10: reserved <= reserved + QUEUE_CNT_W'(1);
				2'b01: reserved <= reserved - QUEUE_CNT_W'(1);
				default: reserved <= reserved;
			endcase

			// sender
			if (launch) begin
				out_req <= 1'b1;
				out_tag <= q_tag[rd_ptr];
			end else if (pop) begin
				out_req <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/tagged_mem.sv ====
module tagged_mem import mem_pkg::*; (
	input  logic         clock,
	input  logic         arst_n,

	// command bus
	input  bus_command_t mem_cmd,
	input  mem_addr_t    mem_addr,
	input  mem_data_t    mem_data,

	// registered grant, 0 when refused
	output mem_tag_t     mem_response,

	// registered return bus
	output mem_tag_t     mem_tag,
	output mem_data_t    mem_data_out
);

	// line storage
	mem_data_t lines [MEM_LINES];

	// per tag state, index 0 unused
	mem_data_t        loaded_data [1:NUM_MEM_TAGS];
	logic [CNT_W-1:0] cycles_left [1:NUM_MEM_TAGS];
	logic [NUM_MEM_TAGS:1] waiting;

	logic [NUM_MEM_TAGS:1] tag_free;
	logic [NUM_MEM_TAGS:1] tag_ready;
	logic [NUM_MEM_TAGS:1] grant_oh;
	logic [NUM_MEM_TAGS:1] ret_oh;
	mem_tag_t              grant_tag;
	mem_tag_t              ret_tag;
	logic                  acquire;

	assign acquire = (mem_cmd == BUS_LOAD) || (mem_cmd == BUS_STORE);

	////////////////////////////////////////////////////////////////////////////
	// tag status and arbitration
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
			// idle tag, counter drained and nothing to deliver
			tag_free[i]  = (cycles_left[i] == '0) && !waiting[i];
			// load whose latency is done
			tag_ready[i] = (cycles_left[i] == '0) && waiting[i];
		end
	end

	// lowest free tag takes the incoming command
	always_comb begin
		grant_tag = '0;
		grant_oh  = '0;
		for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
			if (acquire && tag_free[i] && (grant_tag == '0)) begin
				grant_tag   = mem_tag_t'(i);
				grant_oh[i] = 1'b1;
			end
		end
	end

	// lowest ready tag wins the return bus, one per cycle
	always_comb begin
		ret_tag = '0;
		ret_oh  = '0;
		for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
			if (tag_ready[i] && (ret_tag == '0)) begin
				ret_tag   = mem_tag_t'(i);
				ret_oh[i] = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	// stores land at acceptance
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < MEM_LINES; i++)
				lines[i] <= '0;
		end else if ((grant_tag != '0) && (mem_cmd == BUS_STORE)) begin
			lines[mem_addr] <= mem_data;
		end
	end

	// loads snapshot the line now, deliver it later
	always_ff @(posedge clock) begin
		for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
			if (grant_oh[i] && (mem_cmd == BUS_LOAD))
				loaded_data[i] <= lines[mem_addr];
		end
		if (ret_tag != '0)
			mem_data_out <= loaded_data[ret_tag];
	end

	////////////////////////////////////////////////////////////////////////////
	// latency counters and bus registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i <= NUM_MEM_TAGS; i++)
				cycles_left[i] <= '0;
			waiting      <= '0;
			mem_response <= '0;
			mem_tag      <= '0;
		end else begin
			for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
				if (grant_oh[i]) begin
					// stores hold the tag for the latency too
					cycles_left[i] <= CNT_W'(MEM_LATENCY);
					waiting[i]     <= (mem_cmd == BUS_LOAD);
				end else begin
					if (cycles_left[i] != '0)
						cycles_left[i] <= cycles_left[i] - CNT_W'(1);
					if (ret_oh[i])
						waiting[i] <= 1'b0;
				end
			end
			mem_response <= grant_tag;
			mem_tag      <= ret_tag;
		end
	end

endmodule

// ==== logic/mem_req_port.sv ====
module mem_req_port import mem_pkg::*; (
	input  logic         clock,
	input  logic         arst_n,

	// host request side, four-phase
	input  logic         in_req,
	input  bus_command_t in_cmd,
	input  mem_addr_t    in_addr,
	input  mem_data_t    in_data,
	output logic         in_ack,

	// memory bus
	output bus_command_t mem_cmd,
	output mem_addr_t    mem_addr,
	output mem_data_t    mem_data,
	input  mem_tag_t     mem_response,

	// load credit from the collector
	input  logic         load_room,
	output logic         load_issue
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_ACK
	} state_t;

	state_t state;
	state_t state_next;
	logic   granted;
	logic   credit_ok;
	logic   issuing;

	////////////////////////////////////////////////////////////////////////////
	// bus drive
	////////////////////////////////////////////////////////////////////////////

	// nonzero response means our command took a tag last cycle
	assign granted = (mem_response != '0);

	// stores never wait for credit
	assign credit_ok = (in_cmd != BUS_LOAD) || load_room;

	// drop the command as soon as the grant shows up, so it is not taken twice
	assign issuing = in_req && (state != S_ACK) && !granted && credit_ok;

	assign mem_cmd  = issuing ? in_cmd : BUS_NONE;
	assign mem_addr = in_addr;
	assign mem_data = in_data;

	// one-cycle credit reservation for a granted load
	assign load_issue = granted && (state == S_ISSUE) && (in_cmd == BUS_LOAD);

	// ack is a state decode, rises the cycle after the grant
	assign in_ack = (state == S_ACK);

	////////////////////////////////////////////////////////////////////////////
	// controller
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			// first attempt goes out in the same cycle as in_req
			S_IDLE: if (in_req) state_next = S_ISSUE;
			// keep retrying until a tag comes back
			S_ISSUE: if (granted) state_next = S_ACK;
			// hold ack until the host lets go
			S_ACK: if (!in_req) state_next = S_IDLE;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			state <= S_IDLE;
		else
			state <= state_next;
	end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// memory geometry
	////////////////////////////////////////////////////////////////////////////

	// 64-bit lines, addressed by line index
	localparam int MEM_LINES   = 256;
	localparam int LINE_ADDR_W = 8;

	// tag 0 is reserved for "no tag"
	localparam int NUM_MEM_TAGS = 7;
	localparam int TAG_W        = 3;

	// cycles from acceptance until a load may return
	localparam int MEM_LATENCY = 6;
	localparam int CNT_W       = 3;

	////////////////////////////////////////////////////////////////////////////
	// return queue sizing
	////////////////////////////////////////////////////////////////////////////

	// one slot per tag, so every outstanding load fits
	localparam int QUEUE_DEPTH = NUM_MEM_TAGS;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// bus command encoding
	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_LOAD  = 2'd1,
		BUS_STORE = 2'd2
	} bus_command_t;

	typedef logic [LINE_ADDR_W-1:0] mem_addr_t;
	typedef logic [63:0]            mem_data_t;
	typedef logic [TAG_W-1:0]       mem_tag_t;

endpackage
